// File: conv_pkg.sv
`default_nettype none

package conv_pkg;

    typedef logic [19:0] addr_t;
    typedef logic [7:0]  pix_t;
    typedef logic [9:0]  dim_t;
    typedef logic [3:0]  tap_t;
    typedef logic [19:0] acc_t;

    localparam int TAPS = 9;

    typedef struct packed {
        addr_t weight_base;
        addr_t bias_base;
        addr_t data_base;
        addr_t result_base;
        dim_t  rownum;
        dim_t  columnnum;
        dim_t  filternum;
    } conv_cfg_t;

    typedef struct packed {
        logic  en;
        logic  we;
        addr_t addr;
        pix_t  wdata;
    } mem_req_t;

    // Destination of returning read data, NONE marks an empty slot
    typedef enum logic [1:0] {
        RD_NONE,
        RD_WEIGHT,
        RD_BIAS,
        RD_DATA
    } rd_kind_e;

    typedef struct packed {
        rd_kind_e kind;
        tap_t     tap;
        logic     pad;
        logic     last;
    } rd_tag_t;

    typedef enum logic [1:0] {
        PH_WEIGHT,
        PH_BIAS,
        PH_DATA,
        PH_STORE
    } phase_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD_WEIGHTS,
        S_LOAD_BIAS,
        S_LOAD_WINDOW,
        S_DRAIN,
        S_COMPUTE,
        S_STORE,
        S_NEXT
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: conv_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module conv_ctrl
    import conv_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    input  logic   tap_last,
    input  logic   col_last,
    input  logic   pix_last,
    input  logic   filter_last,
    input  logic   load_done,
    output phase_e phase,
    output logic   issue,
    output logic   mark_last,
    output logic   adv_tap,
    output logic   adv_pixel,
    output logic   adv_filter,
    output logic   clr_tap,
    output logic   compute,
    output logic   conv_finish
);

    ctrl_state_e state;
    ctrl_state_e state_next;
    logic        win_load;
    logic        img_end;

    // Last column of the last row
    assign img_end = col_last && pix_last;

    always_comb
    begin
        state_next = state;
        phase      = PH_WEIGHT;
        issue      = 1'b0;
        mark_last  = 1'b0;
        adv_tap    = 1'b0;
        adv_pixel  = 1'b0;
        adv_filter = 1'b0;
        clr_tap    = 1'b0;
        compute    = 1'b0;
        case (state)
            S_IDLE:
            begin
                if (start)
                begin
                    clr_tap    = 1'b1;
                    state_next = S_LOAD_WEIGHTS;
                end
            end
            S_LOAD_WEIGHTS:
            begin
                issue   = 1'b1;
                phase   = PH_WEIGHT;
                adv_tap = 1'b1;
                if (tap_last)
                    state_next = S_LOAD_BIAS;
            end
            S_LOAD_BIAS:
            begin
                issue      = 1'b1;
                phase      = PH_BIAS;
                mark_last  = 1'b1;
                state_next = S_DRAIN;
            end
            S_LOAD_WINDOW:
            begin
                issue     = 1'b1;
                phase     = PH_DATA;
                adv_tap   = 1'b1;
                mark_last = tap_last;
                if (tap_last)
                    state_next = S_DRAIN;
            end
            S_DRAIN:
            begin
                if (load_done)
                    state_next = win_load ? S_COMPUTE : S_LOAD_WINDOW;
            end
            S_COMPUTE:
            begin
                compute    = 1'b1;
                state_next = S_STORE;
            end
            S_STORE:
            begin
                issue      = 1'b1;
                phase      = PH_STORE;
                state_next = S_NEXT;
            end
            S_NEXT:
            begin
                // Write is on the bus this cycle, counters move on
                adv_pixel = 1'b1;
                if (img_end)
                begin
                    adv_filter = 1'b1;
                    state_next = filter_last ? S_IDLE : S_LOAD_WEIGHTS;
                end
                else
                begin
                    state_next = S_LOAD_WINDOW;
                end
            end
            default:
            begin
                state_next = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state       <= S_IDLE;
            win_load    <= 1'b0;
            conv_finish <= 1'b0;
        end
        else
        begin
            state       <= state_next;
            conv_finish <= (state == S_NEXT) && img_end && filter_last;
            if (state == S_LOAD_BIAS)
                win_load <= 1'b0;
            else if (state == S_LOAD_WINDOW)
                win_load <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: conv_pos_counter.sv
`timescale 1ns/1ns
`default_nettype none

module conv_pos_counter
    import conv_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic adv_tap,
    input  logic clr_tap,
    input  logic adv_pixel,
    input  logic adv_filter,
    input  dim_t cfg_rows,
    input  dim_t cfg_cols,
    input  dim_t cfg_filters,
    output tap_t tap,
    output dim_t row,
    output dim_t column,
    output dim_t filter,
    output logic tap_last,
    output logic col_last,
    output logic pix_last,
    output logic filter_last
);

    assign tap_last    = (tap == tap_t'(TAPS - 1));
    assign col_last    = (column == cfg_cols - dim_t'(1));
    // Last pixel row of the image
    assign pix_last    = (row == cfg_rows - dim_t'(1));
    assign filter_last = (filter == cfg_filters - dim_t'(1));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            tap    <= '0;
            column <= '0;
            row    <= '0;
            filter <= '0;
        end
        else
        begin
            if (clr_tap)
                tap <= '0;
            else if (adv_tap)
                tap <= tap_last ? tap_t'(0) : tap + tap_t'(1);

            if (adv_pixel)
            begin
                column <= col_last ? dim_t'(0) : column + dim_t'(1);
                if (col_last)
                    row <= pix_last ? dim_t'(0) : row + dim_t'(1);
            end

            if (adv_filter)
                filter <= filter_last ? dim_t'(0) : filter + dim_t'(1);
        end
    end

endmodule

`default_nettype wire

// File: conv_addr_gen.sv
`timescale 1ns/1ns
`default_nettype none

module conv_addr_gen
    import conv_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  conv_cfg_t cfg,
    input  phase_e    phase,
    input  logic      issue,
    input  logic      mark_last,
    input  tap_t      tap,
    input  dim_t      row,
    input  dim_t      column,
    input  dim_t      filter,
    input  pix_t      result,
    output mem_req_t  mem_req,
    output rd_tag_t   tag
);

    logic [11:0]        tap_row;
    logic [11:0]        tap_col;
    logic signed [11:0] win_row;
    logic signed [11:0] win_col;
    logic               pad;
    addr_t              addr_d;
    rd_kind_e           kind_d;

    logic     en_q;
    logic     we_q;
    addr_t    addr_q;
    pix_t     wdata_q;
    rd_kind_e kind_q;
    tap_t     tap_q;
    logic     pad_q;
    logic     last_q;

    // Window is centred, tap 0 sits at row-1, column-1
    assign tap_row = 12'(tap / 4'd3);
    assign tap_col = 12'(tap % 4'd3);
    assign win_row = $signed(12'(row) + tap_row - 12'd1);
    assign win_col = $signed(12'(column) + tap_col - 12'd1);

    assign pad = (win_row < 0) || (win_row >= $signed(12'(cfg.rownum)))
              || (win_col < 0) || (win_col >= $signed(12'(cfg.columnnum)));

    always_comb
    begin
        case (phase)
            PH_WEIGHT:
            begin
                addr_d = cfg.weight_base + addr_t'(filter) * addr_t'(TAPS) + addr_t'(tap);
                kind_d = RD_WEIGHT;
            end
            PH_BIAS:
            begin
                addr_d = cfg.bias_base + addr_t'(filter);
                kind_d = RD_BIAS;
            end
            PH_DATA:
            begin
                addr_d = cfg.data_base
                       + addr_t'(dim_t'(win_row)) * addr_t'(cfg.columnnum)
                       + addr_t'(dim_t'(win_col));
                kind_d = RD_DATA;
            end
            default:
            begin
                addr_d = cfg.result_base
                       + addr_t'(filter) * addr_t'(cfg.rownum) * addr_t'(cfg.columnnum)
                       + addr_t'(row) * addr_t'(cfg.columnnum)
                       + addr_t'(column);
                kind_d = RD_NONE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            en_q   <= 1'b0;
            we_q   <= 1'b0;
            kind_q <= RD_NONE;
        end
        else
        begin
            // Padded taps skip the RAM but keep their tag
            en_q   <= issue && !(phase == PH_DATA && pad);
            we_q   <= issue && (phase == PH_STORE);
            kind_q <= issue ? kind_d : RD_NONE;
        end
    end

    always_ff @(posedge clk)
    begin
        addr_q  <= addr_d;
        wdata_q <= result;
        tap_q   <= tap;
        pad_q   <= (phase == PH_DATA) && pad;
        last_q  <= mark_last;
    end

    assign mem_req = '{en: en_q, we: we_q, addr: addr_q, wdata: wdata_q};
    assign tag     = '{kind: kind_q, tap: tap_q, pad: pad_q, last: last_q};

endmodule

`default_nettype wire

// File: conv_window.sv
`timescale 1ns/1ns
`default_nettype none

module conv_window
    import conv_pkg::*;
#(
    parameter int RD_LATENCY = 2
)
(
    input  logic              clk,
    input  logic              rst,
    input  rd_tag_t           tag,
    input  pix_t              mem_rdata,
    output pix_t [TAPS-1:0]   taps,
    output pix_t [TAPS-1:0]   weights,
    output pix_t              bias,
    output logic              load_done
);

    ////////////////////////////////////////////////////////////////////////////
    // Tag pipeline, one slot per cycle of read latency
    ////////////////////////////////////////////////////////////////////////////

    rd_tag_t pipe [RD_LATENCY];
    rd_tag_t tag_out;
    pix_t    din;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < RD_LATENCY; i++)
                pipe[i] <= '{kind: RD_NONE, tap: '0, pad: 1'b0, last: 1'b0};
        end
        else
        begin
            pipe[0] <= tag;
            for (int i = 1; i < RD_LATENCY; i++)
                pipe[i] <= pipe[i-1];
        end
    end

    assign tag_out   = pipe[RD_LATENCY-1];
    assign load_done = (tag_out.kind != RD_NONE) && tag_out.last;

    ////////////////////////////////////////////////////////////////////////////
    // Operand registers
    ////////////////////////////////////////////////////////////////////////////

    // Border taps read as zero
    assign din = tag_out.pad ? pix_t'(0) : mem_rdata;

    always_ff @(posedge clk)
    begin
        case (tag_out.kind)
            RD_WEIGHT: weights[tag_out.tap] <= din;
            RD_BIAS:   bias <= din;
            RD_DATA:   taps[tag_out.tap] <= din;
            default:
            begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: conv_mac.sv
`timescale 1ns/1ns
`default_nettype none

module conv_mac
    import conv_pkg::*;
#(
    parameter int OUT_SHIFT = 4
)
(
    input  logic            clk,
    input  logic            rst,
    input  logic            compute,
    input  pix_t [TAPS-1:0] taps,
    input  pix_t [TAPS-1:0] weights,
    input  pix_t            bias,
    output pix_t            result
);

    acc_t sum;
    acc_t shifted;
    pix_t sat;

    always_comb
    begin
        sum = acc_t'($signed(bias));
        for (int i = 0; i < TAPS; i++)
            sum = sum + acc_t'($signed(taps[i]) * $signed(weights[i]));
        // ReLU then scale down
        shifted = sum[$bits(acc_t)-1] ? acc_t'(0) : (sum >> OUT_SHIFT);
        sat = (shifted > acc_t'(127)) ? pix_t'(127) : pix_t'(shifted);
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            result <= '0;
        else if (compute)
            result <= sat;
    end

endmodule

`default_nettype wire

// File: conv_top.sv
`timescale 1ns/1ns
`default_nettype none

module conv_top
    import conv_pkg::*;
#(
    parameter int RD_LATENCY = 2,
    parameter int OUT_SHIFT  = 4
)
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  conv_cfg_t cfg,
    input  pix_t      mem_rdata,
    output mem_req_t  mem_req,
    output logic      conv_finish
);

    conv_cfg_t       cfg_q;
    phase_e          phase;
    logic            issue;
    logic            mark_last;
    logic            adv_tap;
    logic            adv_pixel;
    logic            adv_filter;
    logic            clr_tap;
    logic            compute;
    logic            tap_last;
    logic            col_last;
    logic            pix_last;
    logic            filter_last;
    logic            load_done;
    tap_t            tap;
    dim_t            row;
    dim_t            column;
    dim_t            filter;
    rd_tag_t         tag;
    pix_t [TAPS-1:0] taps;
    pix_t [TAPS-1:0] weights;
    pix_t            bias;
    pix_t            result;

    // Config taken when the FSM accepts start
    always_ff @(posedge clk)
    begin
        if (clr_tap)
            cfg_q <= cfg;
    end

    conv_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .tap_last    (tap_last),
        .col_last    (col_last),
        .pix_last    (pix_last),
        .filter_last (filter_last),
        .load_done   (load_done),
        .phase       (phase),
        .issue       (issue),
        .mark_last   (mark_last),
        .adv_tap     (adv_tap),
        .adv_pixel   (adv_pixel),
        .adv_filter  (adv_filter),
        .clr_tap     (clr_tap),
        .compute     (compute),
        .conv_finish (conv_finish)
    );

    conv_pos_counter u_pos (
        .clk         (clk),
        .rst         (rst),
        .adv_tap     (adv_tap),
        .clr_tap     (clr_tap),
        .adv_pixel   (adv_pixel),
        .adv_filter  (adv_filter),
        .cfg_rows    (cfg_q.rownum),
        .cfg_cols    (cfg_q.columnnum),
        .cfg_filters (cfg_q.filternum),
        .tap         (tap),
        .row         (row),
        .column      (column),
        .filter      (filter),
        .tap_last    (tap_last),
        .col_last    (col_last),
        .pix_last    (pix_last),
        .filter_last (filter_last)
    );

    conv_addr_gen u_addr (
        .clk       (clk),
        .rst       (rst),
        .cfg       (cfg_q),
        .phase     (phase),
        .issue     (issue),
        .mark_last (mark_last),
        .tap       (tap),
        .row       (row),
        .column    (column),
        .filter    (filter),
        .result    (result),
        .mem_req   (mem_req),
        .tag       (tag)
    );

    conv_window #(
        .RD_LATENCY (RD_LATENCY)
    ) u_window (
        .clk       (clk),
        .rst       (rst),
        .tag       (tag),
        .mem_rdata (mem_rdata),
        .taps      (taps),
        .weights   (weights),
        .bias      (bias),
        .load_done (load_done)
    );

    conv_mac #(
        .OUT_SHIFT (OUT_SHIFT)
    ) u_mac (
        .clk     (clk),
        .rst     (rst),
        .compute (compute),
        .taps    (taps),
        .weights (weights),
        .bias    (bias),
        .result  (result)
    );

endmodule

`default_nettype wire

// File: tb_conv_sva.sv
`timescale 1ns/1ns
`default_nettype none

module tb_conv_sva
    import conv_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input mem_req_t mem_req,
    input logic     conv_finish
);

    // Write strobe only ever comes with enable
    a_we_needs_en: assert property (@(posedge clk) disable iff (rst)
        mem_req.we |-> mem_req.en)
        else $error("mem_req.we high while mem_req.en is low");

    a_reset_quiet: assert property (@(posedge clk)
        rst |=> (!mem_req.en && !mem_req.we && !conv_finish))
        else $error("RAM request or conv_finish active right after reset");

    a_finish_pulse: assert property (@(posedge clk) disable iff (rst)
        conv_finish |=> !conv_finish)
        else $error("conv_finish held for more than one cycle");

    // RAM is idle in the cycle the run ends
    a_finish_idle: assert property (@(posedge clk) disable iff (rst)
        conv_finish |-> !mem_req.en)
        else $error("RAM request active while conv_finish is high");

endmodule

bind conv_top tb_conv_sva u_sva (
    .clk         (clk),
    .rst         (rst),
    .mem_req     (mem_req),
    .conv_finish (conv_finish)
);

`default_nettype wire

// File: tb_conv_checker.sv
`timescale 1ns/1ns
`default_nettype none

module tb_conv_checker
    import conv_pkg::*;
#(
    parameter int OUT_SHIFT = 4
)
(
    input logic     clk,
    input logic     rst,
    input mem_req_t mem_req,
    input logic     conv_finish
);

    // Copy of every input word the testbench loads
    pix_t      shadow [0:1048575];
    conv_cfg_t run_cfg;
    int        errors = 0;
    int        writes = 0;
    int        writes_since_finish = 0;
    longint    cycle = 0;
    longint    last_write_cycle = -10;

    task automatic store_input(input addr_t a, input pix_t v);
        shadow[a] = v;
    endtask

    task automatic begin_run(input conv_cfg_t c);
        run_cfg = c;
    endtask

    // 3x3 window, zero outside the image, then ReLU, shift and clip
    function automatic pix_t expect_result(input int f, input int r, input int c);
        int sum;
        int rr;
        int cc;
        int cols;
        cols = int'(run_cfg.columnnum);
        sum = int'($signed(shadow[run_cfg.bias_base + addr_t'(f)]));
        for (int t = 0; t < TAPS; t++)
        begin
            rr = r + t / 3 - 1;
            cc = c + t % 3 - 1;
            if (rr >= 0 && rr < int'(run_cfg.rownum) && cc >= 0 && cc < cols)
                sum = sum
                    + int'($signed(shadow[run_cfg.data_base + addr_t'(rr * cols + cc)]))
                    * int'($signed(shadow[run_cfg.weight_base + addr_t'(f * TAPS + t)]));
        end
        if (sum < 0)
            sum = 0;
        sum = sum >>> OUT_SHIFT;
        if (sum > 127)
            sum = 127;
        return pix_t'(sum);
    endfunction

    task automatic check_write(input addr_t a, input pix_t d);
        int   off;
        int   px;
        int   cols;
        pix_t exp_v;
        cols = int'(run_cfg.columnnum);
        px = int'(run_cfg.rownum) * cols;
        off = int'(a) - int'(run_cfg.result_base);
        if (off < 0 || off >= px * int'(run_cfg.filternum))
        begin
            $display("Write outside the result region at address %05h", a);
            errors++;
        end
        else
        begin
            exp_v = expect_result(off / px, (off % px) / cols, off % cols);
            if (d !== exp_v)
            begin
                $display("[FAIL] mem_req.wdata at %05h: expected %02h, got %02h",
                         a, exp_v, d);
                errors++;
            end
        end
        writes++;
        writes_since_finish++;
        last_write_cycle = cycle;
    endtask

    always @(posedge clk)
    begin
        cycle = cycle + 1;
        if (!rst && mem_req.en && mem_req.we)
            check_write(mem_req.addr, mem_req.wdata);
        if (!rst && conv_finish)
        begin
            if (writes_since_finish == 0)
            begin
                $display("conv_finish pulsed without any write since the last one");
                errors++;
            end
            if (cycle != last_write_cycle + 1)
            begin
                $display("conv_finish did not follow the last write by one cycle");
                errors++;
            end
            writes_since_finish = 0;
        end
    end

endmodule

`default_nettype wire

// File: tb_conv.sv
`timescale 1ns/1ns
`default_nettype none

module tb_conv
    import conv_pkg::*;
;

    localparam int RD_LATENCY = 2;
    localparam int OUT_SHIFT  = 0;

    logic      clk;
    logic      rst;
    logic      start;
    conv_cfg_t cfg;
    pix_t      mem_rdata;
    mem_req_t  mem_req;
    logic      conv_finish;

    pix_t   ram [0:1048575];
    pix_t   rd_pipe [RD_LATENCY] = '{default: 8'h00};
    logic   ld_we;
    addr_t  ld_addr;
    pix_t   ld_data;
    int     tb_errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    longint cycles = 0;
    longint limit = 0;
    pix_t   saved [$];

    conv_top #(
        .RD_LATENCY (RD_LATENCY),
        .OUT_SHIFT  (OUT_SHIFT)
    ) DUT (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .cfg         (cfg),
        .mem_rdata   (mem_rdata),
        .mem_req     (mem_req),
        .conv_finish (conv_finish)
    );

    tb_conv_checker #(
        .OUT_SHIFT (OUT_SHIFT)
    ) u_checker (
        .clk         (clk),
        .rst         (rst),
        .mem_req     (mem_req),
        .conv_finish (conv_finish)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // RAM model with fixed read latency and a load port
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        if (ld_we)
            ram[ld_addr] <= ld_data;
        if (mem_req.en && mem_req.we)
            ram[mem_req.addr] <= mem_req.wdata;
        // Read port keeps its last word between reads
        if (mem_req.en && !mem_req.we)
            rd_pipe[0] <= ram[mem_req.addr];
        for (int i = 1; i < RD_LATENCY; i++)
            rd_pipe[i] <= rd_pipe[i-1];
    end

    assign mem_rdata = rd_pipe[RD_LATENCY-1];

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles > limit)
        begin
            $display("Timeout after %0d cycles, the engine never finished", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic conv_cfg_t make_cfg(input addr_t base, input int rows,
                                           input int cols, input int filters);
        conv_cfg_t c;
        c.weight_base = base;
        c.bias_base   = base + 20'h00100;
        c.data_base   = base + 20'h00200;
        c.result_base = base + 20'h00400;
        c.rownum      = dim_t'(rows);
        c.columnnum   = dim_t'(cols);
        c.filternum   = dim_t'(filters);
        return c;
    endfunction

    function automatic longint run_budget(input int rows, input int cols, input int filters);
        return longint'(filters * rows * cols * 16 + filters * 16);
    endfunction

    task automatic put(input addr_t a, input pix_t v);
        ld_we   = 1'b1;
        ld_addr = a;
        ld_data = v;
        u_checker.store_input(a, v);
        @(posedge clk);
        #1;
        ld_we = 1'b0;
    endtask

    // Mode 0 random, 1 all ones, 2 large positive, 3 large negative
    task automatic fill_inputs(input conv_cfg_t c, input int mode);
        pix_t v;
        for (int f = 0; f < int'(c.filternum); f++)
        begin
            for (int t = 0; t < TAPS; t++)
            begin
                case (mode)
                    1: v = 8'd1;
                    2: v = 8'd100;
                    3: v = 8'h9c;
                    default: v = 8'($urandom);
                endcase
                put(c.weight_base + addr_t'(f * TAPS + t), v);
            end
            case (mode)
                1, 2: v = 8'h00;
                3: v = 8'h80;
                default: v = 8'($urandom);
            endcase
            put(c.bias_base + addr_t'(f), v);
        end
        for (int p = 0; p < int'(c.rownum) * int'(c.columnnum); p++)
        begin
            case (mode)
                1: v = 8'd1;
                2, 3: v = 8'($urandom_range(127, 1));
                default: v = 8'($urandom);
            endcase
            put(c.data_base + addr_t'(p), v);
        end
    endtask

    task automatic expect_word(input addr_t a, input pix_t exp_v);
        if (ram[a] !== exp_v)
        begin
            $display("[FAIL] ram[%05h]: expected %02h, got %02h", a, exp_v, ram[a]);
            tb_errors++;
        end
    endtask

    task automatic run_conv(input conv_cfg_t c, input bit pulse_mid);
        int wr0;
        int n;
        n = int'(c.filternum) * int'(c.rownum) * int'(c.columnnum);
        wr0 = u_checker.writes;
        u_checker.begin_run(c);
        cfg   = c;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        if (pulse_mid)
        begin
            // Busy engine must ignore this
            repeat (40) @(posedge clk);
            #1;
            cfg   = make_cfg(20'h06000, 2, 2, 1);
            start = 1'b1;
            @(posedge clk);
            #1;
            start = 1'b0;
        end
        while (!conv_finish)
        begin
            @(posedge clk);
            #1;
        end
        if (u_checker.writes - wr0 != n)
        begin
            $display("Run made %0d writes, expected %0d", u_checker.writes - wr0, n);
            tb_errors++;
        end
    endtask

    task automatic report(input string name, input int err0);
        int e;
        e = tb_errors + u_checker.errors - err0;
        tests_run++;
        if (e != 0)
            tests_failed++;
        $display("test %-12s %s (%0d errors)", name, (e == 0) ? "ok" : "failed", e);
    endtask

    initial
    begin
        conv_cfg_t c_a;
        conv_cfg_t c_b;
        int        err0;
        int        n_a;
        int        errs;

        rst     = 1'b1;
        start   = 1'b0;
        cfg     = '0;
        ld_we   = 1'b0;
        ld_addr = '0;
        ld_data = '0;
        void'($urandom(32'hbedfbddf));
        limit = run_budget(6, 5, 2) + run_budget(2, 3, 1) + 2 * run_budget(3, 3, 1)
              + run_budget(4, 4, 1) + run_budget(3, 4, 2) + 1000;

        // Reset
        err0 = 0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (8)
        begin
            if (mem_req.en || mem_req.we || conv_finish)
            begin
                $display("RAM request or conv_finish active after reset before start");
                tb_errors++;
            end
            @(posedge clk);
            #1;
        end
        report("reset", err0);

        // Random image
        err0 = tb_errors + u_checker.errors;
        c_a = make_cfg(20'h00100, 6, 5, 2);
        fill_inputs(c_a, 0);
        run_conv(c_a, 1'b0);
        report("random", err0);

        // Border padding where corners see 4 pixels and edges 6
        err0 = tb_errors + u_checker.errors;
        c_a = make_cfg(20'h01000, 2, 3, 1);
        fill_inputs(c_a, 1);
        run_conv(c_a, 1'b0);
        for (int p = 0; p < 6; p++)
            expect_word(c_a.result_base + addr_t'(p), (p % 3 == 1) ? 8'd6 : 8'd4);
        report("padding", err0);

        // ReLU and saturation
        err0 = tb_errors + u_checker.errors;
        c_a = make_cfg(20'h02000, 3, 3, 1);
        fill_inputs(c_a, 2);
        run_conv(c_a, 1'b0);
        for (int p = 0; p < 9; p++)
            expect_word(c_a.result_base + addr_t'(p), 8'd127);
        c_a = make_cfg(20'h03000, 3, 3, 1);
        fill_inputs(c_a, 3);
        run_conv(c_a, 1'b0);
        for (int p = 0; p < 9; p++)
            expect_word(c_a.result_base + addr_t'(p), 8'd0);
        report("relu_sat", err0);

        // Back-to-back runs with a stray start in the second one
        err0 = tb_errors + u_checker.errors;
        c_a = make_cfg(20'h04000, 4, 4, 1);
        c_b = make_cfg(20'h05000, 3, 4, 2);
        fill_inputs(c_a, 0);
        fill_inputs(c_b, 0);
        run_conv(c_a, 1'b0);
        n_a = 16;
        saved.delete();
        for (int p = 0; p < n_a; p++)
            saved.push_back(ram[c_a.result_base + addr_t'(p)]);
        run_conv(c_b, 1'b1);
        for (int p = 0; p < n_a; p++)
            expect_word(c_a.result_base + addr_t'(p), saved[p]);
        for (int p = 0; p < 16; p++)
            expect_word(c_a.data_base + addr_t'(p), u_checker.shadow[c_a.data_base + addr_t'(p)]);
        for (int p = 0; p < 12; p++)
            expect_word(c_b.data_base + addr_t'(p), u_checker.shadow[c_b.data_base + addr_t'(p)]);
        repeat (4) @(posedge clk);
        #1;
        report("back2back", err0);

        errs = tb_errors + u_checker.errors;
        $display("%0d tests, %0d failed, %0d errors, %0d writes checked",
                 tests_run, tests_failed, errs, u_checker.writes);
        if (errs == 0 && tests_failed == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
conv_pkg.sv
conv_ctrl.sv
conv_pos_counter.sv
conv_addr_gen.sv
conv_window.sv
conv_mac.sv
conv_top.sv
tb_conv_sva.sv
tb_conv_checker.sv
tb_conv.sv

// File: run.sh
#!/usr/bin/env bash
# Compile with Verilator, run the testbench and check the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f build.f --top-module tb_conv -o sim_conv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_conv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
    exit 0
else
    echo "Pass message not found in sim.log"
    exit 1
fi
